// ==== files.f ====
verilog/buf_geom_pkg.sv
verilog/pkt_word_pkg.sv
verilog/chunk_free_list.sv
verilog/chunk_store.sv
verilog/pkt_writer.sv
verilog/pkt_reader.sv
verilog/pkt_buf_top.sv
test/tb_pkt_buf.sv

// ==== Makefile ====
TOP = tb_pkt_buf

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/10ps --top-module $(TOP) -f files.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== test/tb_pkt_buf.sv ====
`timescale 1ns/10ps

module tb_pkt_buf;

  localparam int NUM_CHUNKS  = 8;  // small enough to run the list dry
  localparam int CHUNK_WORDS = 8;
  localparam int MAX_PKTS    = 12;
  localparam int MAX_WORDS   = 32;

  logic                     clk;
  logic                     rst;
  logic                     wren;
  pkt_word_pkg::pkt_data_t  din;
  logic                     eop;
  buf_geom_pkg::chunk_idx_t fl_q;
  logic                     fl_empty;
  logic                     fl_aempty;
  buf_geom_pkg::chunk_idx_t chunk_num;
  logic                     load_req;
  logic                     rel_req;
  logic                     load_rel_ack;
  logic                     rden;
  pkt_word_pkg::pkt_data_t  dout;
  logic                     dout_eop;

  // reference model state
  buf_geom_pkg::chunk_idx_t free_model [$];
  pkt_word_pkg::pkt_data_t  pkt_words [MAX_PKTS][MAX_WORDS];
  buf_geom_pkg::chunk_idx_t pkt_chunks [MAX_PKTS][4];
  int                       pkt_len [MAX_PKTS];
  int                       pkt_nchunks [MAX_PKTS];

  pkt_buf_top #(
    .NUM_CHUNKS  (NUM_CHUNKS),
    .CHUNK_WORDS (CHUNK_WORDS)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .wren         (wren),
    .din          (din),
    .eop          (eop),
    .fl_q         (fl_q),
    .fl_empty     (fl_empty),
    .fl_aempty    (fl_aempty),
    .chunk_num    (chunk_num),
    .load_req     (load_req),
    .rel_req      (rel_req),
    .load_rel_ack (load_rel_ack),
    .rden         (rden),
    .dout         (dout),
    .dout_eop     (dout_eop)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  function automatic pkt_word_pkg::pkt_data_t rand_word();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[71:0];
  endfunction

  // flags and head against the model at the falling edge
  task automatic check_free_list();
    assert (fl_empty == (free_model.size() == 0))
      else report_mismatch($sformatf("fl_empty %0b, model holds %0d",
                                     fl_empty, free_model.size()));
    assert (fl_aempty == (free_model.size() <= 2))
      else report_mismatch($sformatf("fl_aempty %0b, model holds %0d",
                                     fl_aempty, free_model.size()));
    if (free_model.size() > 0)
    begin
      assert (fl_q == free_model[0])
        else report_mismatch($sformatf("fl_q %0d, expected %0d", fl_q, free_model[0]));
    end
  endtask

  task automatic wait_ack(input logic level, input int limit, output int cycles);
    cycles = 0;
    while (load_rel_ack !== level)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > limit)
        abort_on_timeout($sformatf("load_rel_ack to become %0b", level));
    end
  endtask

  task automatic write_packet(input int p, input int len);
    int i;
    pkt_len[p]     = len;
    pkt_nchunks[p] = 0;
    for (i = 0; i < len; i++)
    begin
      @(negedge clk);
      if (i > 0)
        check_free_list();  // pops of the previous word are visible now
      pkt_words[p][i] = rand_word();
      if (i % CHUNK_WORDS == 0)
      begin
        pkt_chunks[p][pkt_nchunks[p]] = free_model.pop_front();
        pkt_nchunks[p]++;
      end
      wren = 1'b1;
      din  = pkt_words[p][i];
      eop  = (i == len - 1);
    end
    @(negedge clk);
    check_free_list();
    wren = 1'b0;
    eop  = 1'b0;
    @(negedge clk);  // last link lands here
  endtask

  task automatic load_packet(input int p);
    int cycles;
    @(negedge clk);
    assert (load_rel_ack == 1'b0) else report_mismatch("ack high before load request");
    chunk_num = pkt_chunks[p][0];
    load_req  = 1'b1;
    wait_ack(1'b1, 20, cycles);
    assert (cycles == 2)
      else report_mismatch($sformatf("load ack after %0d cycles, expected 2", cycles));
    load_req = 1'b0;
    wait_ack(1'b0, 20, cycles);
    assert (cycles == 1)
      else report_mismatch($sformatf("ack fell %0d cycles after load_req, expected 1",
                                     cycles));
  endtask

  task automatic read_words(input int p, input int n);
    int i;
    int k;
    for (i = 0; i <= n; i++)
    begin
      @(negedge clk);
      if (i > 0)
      begin
        k = (i - 1 < pkt_len[p]) ? i - 1 : pkt_len[p] - 1;  // eop word repeats
        assert (dout == pkt_words[p][k])
          else report_mismatch($sformatf("pkt %0d read %0d dout %h, expected %h",
                                         p, i - 1, dout, pkt_words[p][k]));
        assert (dout_eop == (k == pkt_len[p] - 1))
          else report_mismatch($sformatf("pkt %0d read %0d dout_eop %0b",
                                         p, i - 1, dout_eop));
      end
      rden = (i < n);
    end
  endtask

  task automatic release_packet(input int p);
    int cycles;
    int c;
    @(negedge clk);
    assert (load_rel_ack == 1'b0) else report_mismatch("ack high before release request");
    chunk_num = pkt_chunks[p][0];
    rel_req   = 1'b1;
    wait_ack(1'b1, 40, cycles);
    assert (cycles >= pkt_nchunks[p])
      else report_mismatch($sformatf("release ack after %0d cycles for %0d chunks",
                                     cycles, pkt_nchunks[p]));
    for (c = 0; c < pkt_nchunks[p]; c++)
      free_model.push_back(pkt_chunks[p][c]);  // chain order at the tail
    rel_req = 1'b0;
    wait_ack(1'b0, 20, cycles);
    assert (cycles == 1)
      else report_mismatch($sformatf("ack fell %0d cycles after rel_req, expected 1",
                                     cycles));
    check_free_list();
  endtask

  task automatic verify_reset_state();
    @(negedge clk);
    assert (fl_q == '0) else report_mismatch($sformatf("fl_q %0d after reset", fl_q));
    assert (fl_empty == 1'b0) else report_mismatch("fl_empty high after reset");
    check_free_list();
  endtask

  task automatic store_short_packet();
    write_packet(0, 2);
  endtask

  task automatic store_long_packet();
    write_packet(1, 17);  // 8 + 8 + 1 words
    check_free_list();
  endtask

  task automatic read_short_packet();
    load_packet(0);
    read_words(0, 3);  // one read past eop
  endtask

  task automatic release_two_packets();
    write_packet(2, 5);
    release_packet(0);
    release_packet(2);
  endtask

  task automatic read_release_long();
    load_packet(1);
    read_words(1, 12);  // crosses into the second chunk
    release_packet(1);
    assert (u_dut.u_free_list.count == NUM_CHUNKS)
      else report_mismatch($sformatf("free list count %0d after release, expected %0d",
                                     u_dut.u_free_list.count, NUM_CHUNKS));
  endtask

  task automatic exhaust_free_list();
    int j;
    for (j = 0; j < NUM_CHUNKS; j++)
      write_packet(3 + j, 3);
    check_free_list();
    // word offered with no chunk left is dropped
    @(negedge clk);
    wren = 1'b1;
    din  = rand_word();
    eop  = 1'b1;
    @(negedge clk);
    wren = 1'b0;
    eop  = 1'b0;
    check_free_list();
    @(negedge clk);
    check_free_list();
  endtask

  initial
  begin
    void'($urandom(48));
    rst       = 1'b1;
    wren      = 1'b0;
    din       = '0;
    eop       = 1'b0;
    chunk_num = '0;
    load_req  = 1'b0;
    rel_req   = 1'b0;
    rden      = 1'b0;
    for (int i = 0; i < NUM_CHUNKS; i++)
      free_model.push_back(buf_geom_pkg::chunk_idx_t'(i));
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    verify_reset_state();
    store_short_packet();
    store_long_packet();
    read_short_packet();
    release_two_packets();
    read_release_long();
    exhaust_free_list();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== verilog/pkt_buf_top.sv ====
`timescale 1ns/10ps

module pkt_buf_top #(
  parameter int NUM_CHUNKS  = 64,
  parameter int CHUNK_WORDS = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wren,
  input  pkt_word_pkg::pkt_data_t  din,
  input  logic                     eop,
  output buf_geom_pkg::chunk_idx_t fl_q,
  output logic                     fl_empty,
  output logic                     fl_aempty,
  input  buf_geom_pkg::chunk_idx_t chunk_num,
  input  logic                     load_req,
  input  logic                     rel_req,
  output logic                     load_rel_ack,
  input  logic                     rden,
  output pkt_word_pkg::pkt_data_t  dout,
  output logic                     dout_eop
);

  logic                       fl_pop;
  logic                       fl_push;
  buf_geom_pkg::chunk_idx_t   push_idx;
  logic                       wr_en;
  buf_geom_pkg::chunk_idx_t   wr_chunk;
  buf_geom_pkg::word_off_t    wr_off;
  pkt_word_pkg::stored_word_t wr_word;
  logic                       link_wr;
  buf_geom_pkg::chunk_idx_t   link_idx;
  buf_geom_pkg::link_t        link_val;
  logic                       rd_en;
  buf_geom_pkg::chunk_idx_t   rd_chunk;
  buf_geom_pkg::word_off_t    rd_off;
  pkt_word_pkg::stored_word_t rd_word;
  buf_geom_pkg::chunk_idx_t   link_rd_idx;
  buf_geom_pkg::link_t        link_rd_val;

  chunk_free_list #(
    .NUM_CHUNKS (NUM_CHUNKS)
  ) u_free_list (
    .clk      (clk),
    .rst      (rst),
    .pop      (fl_pop),
    .push     (fl_push),
    .push_idx (push_idx),
    .head     (fl_q),
    .empty    (fl_empty),
    .aempty   (fl_aempty)
  );

  chunk_store #(
    .NUM_CHUNKS  (NUM_CHUNKS),
    .CHUNK_WORDS (CHUNK_WORDS)
  ) u_store (
    .clk         (clk),
    .wr_en       (wr_en),
    .wr_chunk    (wr_chunk),
    .wr_off      (wr_off),
    .wr_word     (wr_word),
    .link_wr     (link_wr),
    .link_idx    (link_idx),
    .link_val    (link_val),
    .rd_en       (rd_en),
    .rd_chunk    (rd_chunk),
    .rd_off      (rd_off),
    .link_rd_idx (link_rd_idx),
    .rd_word     (rd_word),
    .link_rd_val (link_rd_val)
  );

  pkt_writer #(
    .CHUNK_WORDS (CHUNK_WORDS)
  ) u_writer (
    .clk      (clk),
    .rst      (rst),
    .wren     (wren),
    .din      (din),
    .eop      (eop),
    .fl_head  (fl_q),
    .fl_empty (fl_empty),
    .fl_pop   (fl_pop),
    .wr_en    (wr_en),
    .wr_chunk (wr_chunk),
    .wr_off   (wr_off),
    .wr_word  (wr_word),
    .link_wr  (link_wr),
    .link_idx (link_idx),
    .link_val (link_val)
  );

  pkt_reader #(
    .CHUNK_WORDS (CHUNK_WORDS)
  ) u_reader (
    .clk          (clk),
    .rst          (rst),
    .chunk_num    (chunk_num),
    .load_req     (load_req),
    .rel_req      (rel_req),
    .rden         (rden),
    .rd_word      (rd_word),
    .link_rd_val  (link_rd_val),
    .load_rel_ack (load_rel_ack),
    .rd_en        (rd_en),
    .rd_chunk     (rd_chunk),
    .rd_off       (rd_off),
    .link_rd_idx  (link_rd_idx),
    .fl_push      (fl_push),
    .push_idx     (push_idx),
    .dout         (dout),
    .dout_eop     (dout_eop)
  );

endmodule

// ==== verilog/pkt_reader.sv ====
`timescale 1ns/10ps

module pkt_reader #(
  parameter int CHUNK_WORDS = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  buf_geom_pkg::chunk_idx_t   chunk_num,
  input  logic                       load_req,
  input  logic                       rel_req,
  input  logic                       rden,
  input  pkt_word_pkg::stored_word_t rd_word,
  input  buf_geom_pkg::link_t        link_rd_val,
  output logic                       load_rel_ack,
  output logic                       rd_en,
  output buf_geom_pkg::chunk_idx_t   rd_chunk,
  output buf_geom_pkg::word_off_t    rd_off,
  output buf_geom_pkg::chunk_idx_t   link_rd_idx,
  output logic                       fl_push,
  output buf_geom_pkg::chunk_idx_t   push_idx,
  output pkt_word_pkg::pkt_data_t    dout,
  output logic                       dout_eop
);

  localparam buf_geom_pkg::word_off_t LAST_OFF = buf_geom_pkg::word_off_t'(CHUNK_WORDS - 1);

  typedef enum logic [2:0] {
    s_idle,
    s_load,
    s_ready,
    s_release,
    s_ack_hold
  } rd_state_t;

  rd_state_t                state;
  logic                     op_load;     // ack_hold returns to ready
  logic                     rd_vld;      // rd_word came from a read last cycle
  buf_geom_pkg::chunk_idx_t ptr_chunk;
  buf_geom_pkg::word_off_t  ptr_off;
  buf_geom_pkg::chunk_idx_t prev_chunk;  // address of the last read
  buf_geom_pkg::word_off_t  prev_off;
  buf_geom_pkg::chunk_idx_t rel_chunk;   // release walk position
  buf_geom_pkg::chunk_idx_t cur_chunk;
  buf_geom_pkg::word_off_t  cur_off;
  logic                     eop_back;
  logic                     chunk_end;
  logic                     accept;
  logic                     start_load;
  logic                     start_rel;

  assign accept     = (state == s_idle) || (state == s_ready);
  assign start_load = accept && load_req;
  assign start_rel  = accept && !load_req && rel_req;

  // eop just came back, so step back onto it and keep repeating it
  assign eop_back  = rd_vld && rd_word.eop;
  assign cur_chunk = eop_back ? prev_chunk : ptr_chunk;
  assign cur_off   = eop_back ? prev_off : ptr_off;
  assign chunk_end = (cur_off == LAST_OFF);

  assign rd_en       = rden && (state == s_ready);
  assign rd_chunk    = cur_chunk;
  assign rd_off      = cur_off;
  assign link_rd_idx = (state == s_release) ? rel_chunk : cur_chunk;
  assign fl_push     = (state == s_release);  // one chunk per cycle
  assign push_idx    = rel_chunk;
  assign dout        = rd_word.data;
  assign dout_eop    = rd_word.eop;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= s_idle;
      op_load      <= 1'b0;
      rd_vld       <= 1'b0;
      load_rel_ack <= 1'b0;
    end
    else
    begin
      rd_vld <= rd_en;
      case (state)
        s_idle, s_ready:
        begin
          if (start_load)
          begin
            op_load <= 1'b1;
            state   <= s_load;
          end
          else if (start_rel)
          begin
            op_load <= 1'b0;
            state   <= s_release;
          end
        end
        s_load:
        begin
          load_rel_ack <= 1'b1;
          state        <= s_ack_hold;
        end
        s_release:
        begin
          if (link_rd_val.last)
          begin
            load_rel_ack <= 1'b1;  // final push goes out on this edge
            state        <= s_ack_hold;
          end
        end
        s_ack_hold:
        begin
          if (!load_req && !rel_req)
          begin
            load_rel_ack <= 1'b0;
            state        <= op_load ? s_ready : s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_load)
    begin
      ptr_chunk <= chunk_num;
      ptr_off   <= '0;
    end
    else if (state == s_ready)
    begin
      if (rd_en)
      begin
        prev_chunk <= cur_chunk;
        prev_off   <= cur_off;
        ptr_chunk  <= chunk_end ? link_rd_val.next : cur_chunk;  // follow the chain
        ptr_off    <= chunk_end ? '0 : cur_off + 1'b1;
      end
      else
      begin
        ptr_chunk <= cur_chunk;
        ptr_off   <= cur_off;
      end
    end
    if (start_rel)
      rel_chunk <= chunk_num;
    else if (state == s_release)
      rel_chunk <= link_rd_val.next;
  end

endmodule

// ==== verilog/pkt_writer.sv ====
`timescale 1ns/10ps

module pkt_writer #(
  parameter int CHUNK_WORDS = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wren,
  input  pkt_word_pkg::pkt_data_t    din,
  input  logic                       eop,
  input  buf_geom_pkg::chunk_idx_t   fl_head,
  input  logic                       fl_empty,
  output logic                       fl_pop,
  output logic                       wr_en,
  output buf_geom_pkg::chunk_idx_t   wr_chunk,
  output buf_geom_pkg::word_off_t    wr_off,
  output pkt_word_pkg::stored_word_t wr_word,
  output logic                       link_wr,
  output buf_geom_pkg::chunk_idx_t   link_idx,
  output buf_geom_pkg::link_t        link_val
);

  localparam buf_geom_pkg::word_off_t LAST_OFF = buf_geom_pkg::word_off_t'(CHUNK_WORDS - 1);

  typedef enum logic {
    s_idle,
    s_in_packet
  } wr_state_t;

  wr_state_t                state;
  buf_geom_pkg::chunk_idx_t cur_chunk;
  buf_geom_pkg::word_off_t  cur_off;    // next offset to fill
  logic                     last_pend;  // eop seen last cycle
  logic                     need_chunk;
  logic                     take;
  logic                     chunk_chg;

  // first word of a packet or a wrapped chunk
  assign need_chunk = (state == s_idle) || (cur_off == '0);
  assign take       = wren && !(need_chunk && fl_empty);
  assign chunk_chg  = take && (state == s_in_packet) && (cur_off == '0);

  assign fl_pop   = take && need_chunk;
  assign wr_en    = take;
  assign wr_chunk = need_chunk ? fl_head : cur_chunk;
  assign wr_off   = need_chunk ? '0 : cur_off;
  assign wr_word  = pkt_word_pkg::stored_word_t'{data: din, eop: eop};

  // The last-chunk link lands one cycle after eop. An eop word that also
  // opens a new chunk then still has the port free for the chain link.
  // Both cases point at cur_chunk. On a change that is the old chunk, and
  // in the cycle after eop it is the eop chunk.
  assign link_wr  = chunk_chg || last_pend;
  assign link_idx = cur_chunk;
  assign link_val = chunk_chg ? buf_geom_pkg::link_t'{next: fl_head, last: 1'b0}
                              : buf_geom_pkg::link_t'{next: '0, last: 1'b1};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= s_idle;
      cur_off   <= '0;
      last_pend <= 1'b0;
    end
    else
    begin
      last_pend <= take && eop;
      if (take)
      begin
        cur_off <= (wr_off == LAST_OFF) ? '0 : wr_off + 1'b1;
        state   <= eop ? s_idle : s_in_packet;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
      cur_chunk <= wr_chunk;
  end

endmodule

// ==== verilog/chunk_store.sv ====
`timescale 1ns/10ps

module chunk_store #(
  parameter int NUM_CHUNKS  = 64,
  parameter int CHUNK_WORDS = 8
) (
  input  logic                       clk,
  input  logic                       wr_en,
  input  buf_geom_pkg::chunk_idx_t   wr_chunk,
  input  buf_geom_pkg::word_off_t    wr_off,
  input  pkt_word_pkg::stored_word_t wr_word,
  input  logic                       link_wr,
  input  buf_geom_pkg::chunk_idx_t   link_idx,
  input  buf_geom_pkg::link_t        link_val,
  input  logic                       rd_en,
  input  buf_geom_pkg::chunk_idx_t   rd_chunk,
  input  buf_geom_pkg::word_off_t    rd_off,
  input  buf_geom_pkg::chunk_idx_t   link_rd_idx,
  output pkt_word_pkg::stored_word_t rd_word,
  output buf_geom_pkg::link_t        link_rd_val
);

  localparam int DEPTH  = NUM_CHUNKS * CHUNK_WORDS;
  localparam int ADDR_W = $clog2(DEPTH);
  localparam int IDX_W  = (NUM_CHUNKS > 1) ? $clog2(NUM_CHUNKS) : 1;

  pkt_word_pkg::stored_word_t data_mem [DEPTH];
  buf_geom_pkg::link_t        link_mem [NUM_CHUNKS];

  // chunk base plus offset into the flat word memory
  function automatic logic [ADDR_W-1:0] word_addr(buf_geom_pkg::chunk_idx_t chunk,
                                                  buf_geom_pkg::word_off_t  off);
    return ADDR_W'(int'(chunk) * CHUNK_WORDS + int'(off));
  endfunction

  always_ff @(posedge clk)
  begin
    if (wr_en)
      data_mem[word_addr(wr_chunk, wr_off)] <= wr_word;
    if (rd_en)
      rd_word <= data_mem[word_addr(rd_chunk, rd_off)];  // holds between reads
  end

  always_ff @(posedge clk)
  begin
    if (link_wr)
      link_mem[link_idx[IDX_W-1:0]] <= link_val;
  end

  // async read lets the reader step one link per cycle
  assign link_rd_val = link_mem[link_rd_idx[IDX_W-1:0]];

endmodule

// ==== verilog/chunk_free_list.sv ====
`timescale 1ns/10ps

module chunk_free_list #(
  parameter int NUM_CHUNKS = 64
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pop,
  input  logic                     push,
  input  buf_geom_pkg::chunk_idx_t push_idx,
  output buf_geom_pkg::chunk_idx_t head,
  output logic                     empty,
  output logic                     aempty
);

  localparam int PTR_W = (NUM_CHUNKS > 1) ? $clog2(NUM_CHUNKS) : 1;
  localparam int CNT_W = $clog2(NUM_CHUNKS + 1);

  buf_geom_pkg::chunk_idx_t fl_mem [NUM_CHUNKS];
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W-1:0]         wr_ptr;
  logic [CNT_W-1:0]         count;
  logic                     pop_ok;

  // circular pointer step for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(NUM_CHUNKS - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign pop_ok = pop && !empty;  // pop on empty is dropped
  assign head   = fl_mem[rd_ptr];
  assign empty  = (count == '0);
  assign aempty = (count <= CNT_W'(2));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // every chunk free in ascending order
      for (int i = 0; i < NUM_CHUNKS; i++)
        fl_mem[i] <= buf_geom_pkg::chunk_idx_t'(i);
      rd_ptr <= '0;
      wr_ptr <= '0;  // list full so the tail wraps onto head
      count  <= CNT_W'(NUM_CHUNKS);
    end
    else
    begin
      if (push)
      begin
        fl_mem[wr_ptr] <= push_idx;
        wr_ptr         <= ptr_inc(wr_ptr);
      end
      if (pop_ok)
        rd_ptr <= ptr_inc(rd_ptr);
      if (push && !pop_ok)
        count <= count + 1'b1;
      else if (pop_ok && !push)
        count <= count - 1'b1;
    end
  end

endmodule

// ==== verilog/pkt_word_pkg.sv ====
package pkt_word_pkg;

  // top byte is control and the rest payload
  localparam int CTRL_W    = 8;
  localparam int PAYLOAD_W = 64;
  localparam int DATA_W    = CTRL_W + PAYLOAD_W;

  // one packet word as seen on din and dout
  typedef logic [DATA_W-1:0] pkt_data_t;

  // word as kept in the chunk memory
  typedef struct packed {
    pkt_data_t data;
    logic      eop;  // last word of the packet
  } stored_word_t;

endpackage

// ==== verilog/buf_geom_pkg.sv ====
package buf_geom_pkg;

  // largest buffer the index types are sized for
  localparam int MAX_CHUNKS      = 512;
  localparam int MAX_CHUNK_WORDS = 16;

  localparam int CHUNK_IDX_W = $clog2(MAX_CHUNKS);
  localparam int WORD_OFF_W  = $clog2(MAX_CHUNK_WORDS);

  // chunk number in the shared memory
  typedef logic [CHUNK_IDX_W-1:0] chunk_idx_t;

  // word position inside a chunk
  typedef logic [WORD_OFF_W-1:0] word_off_t;

  // one entry of the link memory, one per chunk
  typedef struct packed {
    chunk_idx_t next;  // following chunk of the packet
    logic       last;  // final chunk where next is unused
  } link_t;

endpackage
